/* soc_bus.f */
+incdir+testbench
src/soc_pkg.sv
src/bus_if.sv
src/data_bus.sv
src/ram_controller.sv
src/timer_controller.sv
src/gpio_controller.sv
src/soc_bus_top.sv
testbench/tb_soc_bus.sv

/* testbench/soc_model.svh */
`ifndef SOC_MODEL_SVH
`define SOC_MODEL_SVH

localparam int RAM_DEPTH = 256;
localparam int PIN_COUNT = 16;

logic [31:0]          ram_shadow [RAM_DEPTH];
logic [PIN_COUNT-1:0] gpio_shadow;
logic [31:0]          compare_shadow;
logic                 status_shadow;

// region in [31:28], word index in [27:2]
function automatic logic [31:0] ram_address(input int idx);
    return {4'd0, 26'(idx), 2'b00};
endfunction

// i/o region, device in [11:8], register in [7:2]
function automatic logic [31:0] io_address(input logic [3:0] dev, input logic [5:0] reg_idx);
    return {4'd1, 16'd0, dev, reg_idx, 2'b00};
endfunction

function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                            input logic [31:0] data,
                                            input logic [3:0]  be);
    logic [31:0] word;
    word = old_word;
    for (int i = 0; i < 4; i++) begin
        if (be[i])
            word[8*i +: 8] = data[8*i +: 8];
    end
    return word;
endfunction

// preload pattern, spreads every index bit over the word
function automatic logic [31:0] fill_word(input int idx);
    return (32'(idx) * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
endfunction

function automatic void ram_store(input int idx, input logic [31:0] data, input logic [3:0] be);
    ram_shadow[idx] = merge_bytes(ram_shadow[idx], data, be);
endfunction

function automatic void gpio_store(input logic [31:0] data, input logic [3:0] be);
    logic [31:0] word;
    word = merge_bytes(32'(gpio_shadow), data, be);
    gpio_shadow = word[PIN_COUNT-1:0];
endfunction

function automatic void reset_model();
    gpio_shadow    = '0;
    compare_shadow = '0;
    // count and compare both start at zero, so the first edge matches
    status_shadow  = 1'b1;
endfunction

`endif

/* testbench/tb_soc_bus.sv */
`timescale 1ns/1ps

module tb_soc_bus;
    import soc_pkg::*;

    `include "soc_model.svh"

    localparam real CLK_PERIOD = 8.0;
    // reset, preload, random ram, back-to-back, timer, gpio, unmapped
    localparam int CYCLE_BUDGET = 10 + RAM_DEPTH + 200 * 3 + 70 + 40 + 16 * 5 + 30;
    localparam int MARGIN = 200;

    logic                 clk;
    logic                 rst_n;
    logic [31:0]          addr;
    logic [31:0]          wdata;
    logic [3:0]           be;
    logic                 read;
    logic                 write;
    logic [31:0]          rdata;
    logic                 rvalid;
    logic                 bus_error;
    logic                 timer_irq;
    logic [PIN_COUNT-1:0] gpio_in;
    logic [PIN_COUNT-1:0] gpio_out;

    logic [15:0] lfsr = 16'd7695;
    int          errors;
    int          checks;
    int          written[$];    // ram indices in write order

    soc_bus_top #(
        .RAM_WORDS  (RAM_DEPTH),
        .GPIO_WIDTH (PIN_COUNT)
    ) dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .addr      (addr),
        .wdata     (wdata),
        .be        (be),
        .read      (read),
        .write     (write),
        .rdata     (rdata),
        .rvalid    (rvalid),
        .bus_error (bus_error),
        .timer_irq (timer_irq),
        .gpio_in   (gpio_in),
        .gpio_out  (gpio_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // all bus tasks start and end on a falling edge
    task automatic bus_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] b);
        addr  = a;
        wdata = d;
        be    = b;
        write = 1'b1;
        @(negedge clk);
        write = 1'b0;
    endtask

    task automatic bus_read(input logic [31:0] a, input string name, output logic [31:0] data);
        addr = a;
        read = 1'b1;
        @(negedge clk);
        read = 1'b0;
        checks++;
        if (rvalid !== 1'b1) begin
            errors++;
            $display("%s: no read response one cycle after the read strobe", name);
        end
        data = rdata;
    endtask

    task automatic probe_unmapped(input string name, input logic [31:0] a, input logic is_write);
        addr  = a;
        wdata = rand_bits(32);
        be    = 4'hf;
        write = is_write;
        read  = ~is_write;
        @(negedge clk);
        write = 1'b0;
        read  = 1'b0;
        check_value({name, " bus_error"}, 32'd1, bus_error);
        check_value({name, " rvalid"}, 32'd0, rvalid);
        check_value({name, " rdata"}, 32'd0, rdata);
        @(negedge clk);
        check_value({name, " bus_error pulse"}, 32'd0, bus_error);    // one cycle only
    endtask

    task automatic random_ram_test();
        int          idx;
        logic [31:0] d;
        logic [3:0]  b;
        logic [31:0] data;
        for (int i = 0; i < 200; i++) begin
            idx = rand_bits($clog2(RAM_DEPTH));
            d   = rand_bits(32);
            b   = 4'(rand_bits(4));
            bus_write(ram_address(idx), d, b);
            ram_store(idx, d, b);
            written.push_back(idx);
        end
        foreach (written[i]) begin
            bus_read(ram_address(written[i]), "ram read-back", data);
            check_value("ram read-back", ram_shadow[written[i]], data);
            @(negedge clk);
            check_value("ram rvalid single cycle", 32'd0, rvalid);
        end
    endtask

    task automatic back_to_back_reads();
        int n = 64;
        addr = ram_address(written[0]);
        read = 1'b1;
        for (int i = 1; i <= n; i++) begin
            @(negedge clk);
            check_value("back-to-back rvalid", 32'd1, rvalid);
            check_value("back-to-back rdata", ram_shadow[written[i-1]], rdata);
            if (i < n)
                addr = ram_address(written[i]);
            else
                read = 1'b0;
        end
    endtask

    task automatic timer_test();
        logic [31:0] start;
        logic [31:0] first;
        logic [31:0] second;
        logic [31:0] data;
        int          gap;
        check_value("timer irq after reset", status_shadow, timer_irq);
        start = rand_bits(32);
        gap   = 4 + rand_bits(3);
        bus_write(io_address(4'd0, TMR_COUNT), start, 4'hf);
        bus_read(io_address(4'd0, TMR_COUNT), "timer count", first);
        check_value("timer count load", start, first);
        repeat (gap - 1) @(negedge clk);
        bus_read(io_address(4'd0, TMR_COUNT), "timer count", second);
        check_value("timer count gap", gap, second - first);
        compare_shadow = second + 32'd10;
        bus_write(io_address(4'd0, TMR_COMPARE), compare_shadow, 4'hf);
        bus_write(io_address(4'd0, TMR_STATUS), 32'd1, 4'hf);
        status_shadow = 1'b0;
        check_value("timer irq cleared", status_shadow, timer_irq);
        // match lands on the tenth edge after the second read
        repeat (7) @(negedge clk);
        check_value("timer irq before match", 32'd0, timer_irq);
        @(negedge clk);
        status_shadow = 1'b1;
        check_value("timer irq on match", status_shadow, timer_irq);
        bus_read(io_address(4'd0, TMR_STATUS), "timer status", data);
        check_value("timer status set", status_shadow, data);
        bus_write(io_address(4'd0, TMR_STATUS), 32'd1, 4'hf);
        status_shadow = 1'b0;
        check_value("timer irq after clear", status_shadow, timer_irq);
        bus_read(io_address(4'd0, TMR_STATUS), "timer status", data);
        check_value("timer status clear", status_shadow, data);
    endtask

    task automatic gpio_test();
        logic [31:0] d;
        logic [3:0]  b;
        logic [31:0] data;
        for (int i = 0; i < 16; i++) begin
            d = rand_bits(32);
            b = 4'(rand_bits(4));
            bus_write(io_address(4'd1, GPIO_OUT_REG), d, b);
            gpio_store(d, b);
            check_value("gpio_out after write", gpio_shadow, gpio_out);
            bus_read(io_address(4'd1, GPIO_OUT_REG), "gpio out read", data);
            check_value("gpio out read", gpio_shadow, data);
            gpio_in = PIN_COUNT'(rand_bits(PIN_COUNT));
            repeat (2) @(negedge clk);    // synchronizer depth
            bus_read(io_address(4'd1, GPIO_IN_REG), "gpio in read", data);
            check_value("gpio in read", gpio_in, data);
        end
    endtask

    task automatic unmapped_test();
        int          idx;
        logic [31:0] data;
        idx = written[0];
        // these alias onto a live word if the decoder lets them through
        probe_unmapped("ram index out of range", ram_address(RAM_DEPTH + idx), 1'b1);
        probe_unmapped("ram index out of range", ram_address(RAM_DEPTH * 3 + idx), 1'b0);
        probe_unmapped("region 2", ram_address(idx) | 32'h2000_0000, 1'b1);
        probe_unmapped("region 2", io_address(4'd1, GPIO_OUT_REG) ^ 32'h3000_0000, 1'b0);
        probe_unmapped("io device 3", io_address(4'd3, GPIO_OUT_REG), 1'b1);
        probe_unmapped("io device 3", io_address(4'd3, GPIO_IN_REG), 1'b0);
        bus_read(ram_address(idx), "ram after unmapped", data);
        check_value("ram after unmapped", ram_shadow[idx], data);
        bus_read(io_address(4'd1, GPIO_OUT_REG), "gpio after unmapped", data);
        check_value("gpio after unmapped", gpio_shadow, data);
        check_value("gpio pins after unmapped", gpio_shadow, gpio_out);
    endtask

    initial begin
        errors  = 0;
        checks  = 0;
        rst_n   = 1'b0;
        addr    = '0;
        wdata   = '0;
        be      = '0;
        read    = 1'b0;
        write   = 1'b0;
        gpio_in = '0;
        reset_model();
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < RAM_DEPTH; i++) begin    // ram powers up undefined
            bus_write(ram_address(i), fill_word(i), 4'hf);
            ram_store(i, fill_word(i), 4'hf);
        end
        random_ram_test();
        back_to_back_reads();
        timer_test();
        gpio_test();
        unmapped_test();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    initial begin
        repeat (CYCLE_BUDGET + MARGIN) @(posedge clk);
        $display("timeout: tests still running after %0d cycles", CYCLE_BUDGET + MARGIN);
        $display("Verification failed");
        $finish;
    end

endmodule

/* src/soc_bus_top.sv */
`timescale 1ns/1ps

module soc_bus_top #(
    parameter int RAM_WORDS  = 1024,
    parameter int GPIO_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [31:0]           addr,
    input  logic [31:0]           wdata,
    input  logic [3:0]            be,
    input  logic                  read,
    input  logic                  write,
    output logic [31:0]           rdata,
    output logic                  rvalid,
    output logic                  bus_error,
    output logic                  timer_irq,
    input  logic [GPIO_WIDTH-1:0] gpio_in,
    output logic [GPIO_WIDTH-1:0] gpio_out
);

    bus_if ram_bus ();
    bus_if timer_bus ();
    bus_if gpio_bus ();

    // decoder sits between the external master and the peripherals
    data_bus #(
        .RAM_WORDS (RAM_WORDS)
    ) data_bus_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .addr      (addr),
        .wdata     (wdata),
        .be        (be),
        .read      (read),
        .write     (write),
        .rdata     (rdata),
        .rvalid    (rvalid),
        .bus_error (bus_error),
        .ram       (ram_bus.master),
        .timer     (timer_bus.master),
        .gpio      (gpio_bus.master)
    );

    ram_controller #(
        .RAM_WORDS (RAM_WORDS)
    ) ram_controller_i (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (ram_bus.slave)
    );

    timer_controller timer_controller_i (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (timer_bus.slave),
        .irq   (timer_irq)
    );

    gpio_controller #(
        .GPIO_WIDTH (GPIO_WIDTH)
    ) gpio_controller_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus      (gpio_bus.slave),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out)
    );

endmodule

/* src/gpio_controller.sv */
`timescale 1ns/1ps

module gpio_controller #(
    parameter int GPIO_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,
    bus_if.slave                  bus,
    input  logic [GPIO_WIDTH-1:0] gpio_in,
    output logic [GPIO_WIDTH-1:0] gpio_out
);
    import soc_pkg::*;

    logic [GPIO_WIDTH-1:0] out_q;
    logic [31:0]           out_next;
    logic [GPIO_WIDTH-1:0] in_meta;
    logic [GPIO_WIDTH-1:0] in_sync;
    logic [31:0]           rdata_q;
    logic                  rvalid_q;

    // merge enabled byte lanes into the latch
    always_comb begin
        out_next = 32'(out_q);
        for (int i = 0; i < 4; i++) begin
            if (bus.be[i])
                out_next[8*i +: 8] = bus.wdata[8*i +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_q    <= '0;
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= bus.read;
            if (bus.write && bus.addr.io.reg_idx == GPIO_OUT_REG)
                out_q <= out_next[GPIO_WIDTH-1:0];
        end
    end

    // two-flop input sync plus read register
    always_ff @(posedge clk) begin
        in_meta <= gpio_in;
        in_sync <= in_meta;
        if (bus.read) begin
            case (bus.addr.io.reg_idx)
                GPIO_OUT_REG: rdata_q <= 32'(out_q);
                GPIO_IN_REG:  rdata_q <= 32'(in_sync);
                default:      rdata_q <= '0;
            endcase
        end
    end

    assign bus.rdata  = rdata_q;
    assign bus.rvalid = rvalid_q;
    assign gpio_out   = out_q;

endmodule

/* src/timer_controller.sv */
`timescale 1ns/1ps

module timer_controller (
    input  logic  clk,
    input  logic  rst_n,
    bus_if.slave  bus,
    output logic  irq
);
    import soc_pkg::*;

    logic [31:0] count;
    logic [31:0] compare;
    logic        status;    // sticky match
    logic [31:0] rdata_q;
    logic        rvalid_q;
    logic [5:0]  reg_idx;

    assign reg_idx = bus.addr.io.reg_idx;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count    <= '0;
            compare  <= '0;
            status   <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= bus.read;
            if (bus.write && reg_idx == TMR_COUNT)
                count <= bus.wdata;    // load, count on from here
            else
                count <= count + 32'd1;
            if (bus.write && reg_idx == TMR_COMPARE)
                compare <= bus.wdata;
            // a fresh match wins over a clear
            if (count == compare)
                status <= 1'b1;
            else if (bus.write && reg_idx == TMR_STATUS && bus.wdata[0])
                status <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.read) begin
            case (reg_idx)
                TMR_COUNT:   rdata_q <= count;
                TMR_COMPARE: rdata_q <= compare;
                TMR_STATUS:  rdata_q <= {31'd0, status};
                default:     rdata_q <= '0;
            endcase
        end
    end

    assign bus.rdata  = rdata_q;
    assign bus.rvalid = rvalid_q;
    assign irq        = status;

    // interrupt only ever rises after a compare match
    a_irq_cause: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(irq) |-> $past(count == compare))
        else $error("timer irq rose without a compare match");

endmodule

/* src/ram_controller.sv */
`timescale 1ns/1ps

module ram_controller #(
    parameter int RAM_WORDS = 1024
) (
    input  logic  clk,
    input  logic  rst_n,
    bus_if.slave  bus
);
    import soc_pkg::*;

    localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    logic [31:0]      mem [RAM_WORDS];
    logic [IDX_W-1:0] idx;
    logic [31:0]      rdata_q;
    logic             rvalid_q;

    assign idx = bus.addr.ram.word_idx[IDX_W-1:0];

    // byte-lane writes, registered read port
    always_ff @(posedge clk) begin
        if (bus.write) begin
            for (int i = 0; i < 4; i++) begin
                if (bus.be[i])
                    mem[idx][8*i +: 8] <= bus.wdata[8*i +: 8];
            end
        end
        if (bus.read)
            rdata_q <= mem[idx];
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            rvalid_q <= 1'b0;
        else
            rvalid_q <= bus.read;
    end

    assign bus.rdata  = rdata_q;
    assign bus.rvalid = rvalid_q;

    // decoder must filter out-of-range indices
    a_idx_range: assert property (@(posedge clk) disable iff (!rst_n)
        (bus.read || bus.write) |-> (bus.addr.ram.word_idx < RAM_WORDS))
        else $error("ram strobe with word index out of range");

endmodule

/* src/data_bus.sv */
`timescale 1ns/1ps

module data_bus #(
    parameter int RAM_WORDS = 1024
) (
    input  logic               clk,
    input  logic               rst_n,
    input  soc_pkg::bus_addr_t addr,
    input  logic [31:0]        wdata,
    input  logic [3:0]         be,
    input  logic               read,
    input  logic               write,
    output logic [31:0]        rdata,
    output logic               rvalid,
    output logic               bus_error,
    bus_if.master              ram,
    bus_if.master              timer,
    bus_if.master              gpio
);
    import soc_pkg::*;

    logic       sel_ram;
    logic       sel_timer;
    logic       sel_gpio;
    logic       mapped;
    logic [2:0] sel_q;    // one-hot gpio, timer, ram
    logic       err_q;

    always_comb begin
        sel_ram   = 1'b0;
        sel_timer = 1'b0;
        sel_gpio  = 1'b0;
        case (addr.ram.region)
            REGION_RAM: sel_ram = (addr.ram.word_idx < RAM_WORDS);
            REGION_IO: begin
                sel_timer = (addr.io.device == DEV_TIMER);
                sel_gpio  = (addr.io.device == DEV_GPIO);
            end
            default: ;    // unmapped region
        endcase
    end

    assign mapped = sel_ram | sel_timer | sel_gpio;

    // address and write data fan out to every slave
    assign ram.addr    = addr;
    assign ram.wdata   = wdata;
    assign ram.be      = be;
    assign ram.read    = read & sel_ram;
    assign ram.write   = write & sel_ram;

    assign timer.addr  = addr;
    assign timer.wdata = wdata;
    assign timer.be    = be;
    assign timer.read  = read & sel_timer;
    assign timer.write = write & sel_timer;

    assign gpio.addr   = addr;
    assign gpio.wdata  = wdata;
    assign gpio.be     = be;
    assign gpio.read   = read & sel_gpio;
    assign gpio.write  = write & sel_gpio;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sel_q <= 3'b000;
            err_q <= 1'b0;
        end else begin
            sel_q <= read ? {sel_gpio, sel_timer, sel_ram} : 3'b000;
            err_q <= (read | write) & ~mapped;
        end
    end

    assign rvalid    = |(sel_q & {gpio.rvalid, timer.rvalid, ram.rvalid});
    assign bus_error = err_q;

    // response mux, zero when nothing returns
    always_comb begin
        rdata = '0;
        if (sel_q[0] && ram.rvalid)
            rdata = ram.rdata;
        else if (sel_q[1] && timer.rvalid)
            rdata = timer.rdata;
        else if (sel_q[2] && gpio.rvalid)
            rdata = gpio.rdata;
    end

    a_no_rw_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        !(read && write))
        else $error("read and write strobes high together");

    a_one_slave: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({gpio.read | gpio.write, timer.read | timer.write, ram.read | ram.write}))
        else $error("more than one slave strobed");

    // every mapped read answers on the next cycle, and nothing else does
    a_rvalid_timing: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid == $past(read && mapped))
        else $error("rvalid not one cycle after read");

endmodule

/* src/bus_if.sv */
`timescale 1ns/1ps

interface bus_if;
    import soc_pkg::*;

    bus_addr_t   addr;
    logic [31:0] wdata;
    logic [3:0]  be;
    logic        read;
    logic        write;
    logic [31:0] rdata;
    logic        rvalid;

    modport master (
        output addr, wdata, be, read, write,
        input  rdata, rvalid
    );

    // peripheral side
    modport slave (
        input  addr, wdata, be, read, write,
        output rdata, rvalid
    );

endinterface

/* src/soc_pkg.sv */
package soc_pkg;

    typedef enum logic [3:0] {
        REGION_RAM = 4'd0,
        REGION_IO  = 4'd1
    } region_e;

    typedef enum logic [3:0] {
        DEV_TIMER = 4'd0,
        DEV_GPIO  = 4'd1
    } device_e;

    // ram view of a bus address
    typedef struct packed {
        region_e     region;
        logic [25:0] word_idx;
        logic [1:0]  byte_off;
    } ram_addr_t;

    // i/o view of a bus address
    typedef struct packed {
        region_e     region;
        logic [15:0] unused;
        device_e     device;
        logic [5:0]  reg_idx;
        logic [1:0]  byte_off;
    } io_addr_t;

    typedef union packed {
        ram_addr_t ram;
        io_addr_t  io;
    } bus_addr_t;

    // timer register map
    localparam logic [5:0] TMR_COUNT   = 6'd0;
    localparam logic [5:0] TMR_COMPARE = 6'd1;
    localparam logic [5:0] TMR_STATUS  = 6'd2;

    // gpio register map
    localparam logic [5:0] GPIO_OUT_REG = 6'd0;
    localparam logic [5:0] GPIO_IN_REG  = 6'd1;

endpackage
